// File: project.f
+incdir+verification
src/fds_pkg.sv
src/fds_timer_irq.sv
src/fds_disk_seq.sv
src/fds_addr_map.sv
src/fds_read_mux.sv
src/fds_mapper.sv
verification/fds_tb.sv

// File: run.sh
#!/bin/sh
# build and run the FDS mapper testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module fds_tb -f project.f
out=$(./obj_dir/Vfds_tb)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"

// File: src/fds_addr_map.sv
// combinational PRG bank translation, PRG access permission and CHR/nametable mirroring
`timescale 1ns/10ps

module fds_addr_map (
	input  fds_pkg::cpu_bus_t               bus,
	input  fds_pkg::disk_ctrl_t             ctrl,
	input  logic [fds_pkg::DISK_OFS_W-1:0]  disk_ofs,
	output logic [fds_pkg::PRG_AOUT_W-1:0]  prg_aout,
	output logic                            prg_allow,
	output fds_pkg::chr_map_t               chr
);

	logic [5:0] prg_bank;
	logic       window_open;
	logic       wram_range;   // $6000-$DFFF
	logic       ofs_port;     // disk offset readback addresses
	logic       a10;

	assign window_open = ctrl.rd_open | ctrl.wr_open;
	assign wram_range  = bus.addr[15] ^ (&bus.addr[14:13]);

	assign ofs_port = ((bus.addr == fds_pkg::DISK_READ_LO)  |
	                   (bus.addr == fds_pkg::DISK_READ_HI)  |
	                   (bus.addr == fds_pkg::DISK_WRITE_LO) |
	                   (bus.addr == fds_pkg::DISK_WRITE_HI)) & ~window_open;

	// e000-ffff is bios, or the disk image for one cycle after a handshake
	always_comb begin
		if (bus.addr[15:13] == 3'b111) begin
			if (window_open)
				prg_bank = {1'b1, disk_ofs[17:13]};
			else
				prg_bank = 6'd0;
		end else begin
			prg_bank = {4'b0001, bus.addr[14:13]}; // work ram
		end
	end

	assign prg_aout = {prg_bank, bus.addr[12:0]};

	always_comb begin
		if (bus.write)
			prg_allow = ctrl.wr_open | wram_range; // open write window reaches the image
		else
			prg_allow = (bus.addr[15:13] == 3'b011) | (bus.addr[15] & ~ofs_port);
	end

	// pattern tables pass A10, nametables pick A10 or A11
	always_comb begin
		if (!bus.addr[13])
			a10 = bus.addr[10];
		else if (ctrl.vertical)
			a10 = bus.addr[10];
		else
			a10 = bus.addr[11];
	end

	assign chr.chr_bank = {6'd0, bus.addr[12:11], a10};
	assign chr.ciram_ce = bus.addr[13];

endmodule

// File: src/fds_disk_seq.sv
// disk control/side registers, lo/hi read and write sequencers, disk pointer and save flag
`timescale 1ns/10ps

module fds_disk_seq (
	input  logic                            clk20,
	input  logic                            reset,
	input  logic                            cpu_ce,
	input  fds_pkg::cpu_bus_t               bus,
	input  logic                            io_en,
	output fds_pkg::disk_ctrl_t             ctrl,
	output logic [fds_pkg::DISK_OFS_W-1:0]  disk_ofs,
	output logic                            disk_end,
	output logic                            saved
);

	fds_pkg::seq_state_t wr_state;
	fds_pkg::seq_state_t rd_state;

	logic [fds_pkg::DISK_POS_W-1:0] disk_pos;
	logic [fds_pkg::DISK_OFS_W-1:0] side_base;
	logic [1:0]                     side;
	logic                           diskreset;
	logic                           write_en;
	logic                           vertical;
	logic                           rd_cyc;
	logic                           rd_open;
	logic                           wr_open;

	// lo arms, hi while armed opens, anything else drops back to idle
	function automatic fds_pkg::seq_state_t seq_next(
		input fds_pkg::seq_state_t cur,
		input logic                lo_hit,
		input logic                hi_hit
	);
		fds_pkg::seq_state_t nxt;
		if (lo_hit)
			nxt = fds_pkg::SEQ_ARMED;
		else if (hi_hit && cur == fds_pkg::SEQ_ARMED)
			nxt = fds_pkg::SEQ_OPEN;
		else
			nxt = fds_pkg::SEQ_IDLE;
		return nxt;
	endfunction

	assign rd_cyc  = ~bus.write;
	assign rd_open = (rd_state == fds_pkg::SEQ_OPEN);
	assign wr_open = (wr_state == fds_pkg::SEQ_OPEN);

	always_ff @(posedge clk20) begin
		if (reset) begin
			wr_state  <= fds_pkg::SEQ_IDLE;
			rd_state  <= fds_pkg::SEQ_IDLE;
			disk_pos  <= '0;
			side      <= 2'd0;
			diskreset <= 1'b0;
			write_en  <= 1'b0;
			vertical  <= 1'b0;
			saved     <= 1'b0;
		end else if (cpu_ce) begin
			if (bus.write && bus.addr == fds_pkg::REG_DISK_CTRL) begin
				diskreset <= bus.wdata[1];
				write_en  <= ~bus.wdata[2]; // active low on the bus
				vertical  <= ~bus.wdata[3];
			end
			if (bus.write && bus.addr == fds_pkg::REG_DISK_SIDE)
				side <= bus.wdata[1:0];

			wr_state <= seq_next(wr_state,
				rd_cyc & write_en & (bus.addr == fds_pkg::DISK_WRITE_LO),
				rd_cyc & (bus.addr == fds_pkg::DISK_WRITE_HI));
			rd_state <= seq_next(rd_state,
				rd_cyc & (bus.addr == fds_pkg::DISK_READ_LO),
				rd_cyc & (bus.addr == fds_pkg::DISK_READ_HI));

			if (wr_open)
				saved <= 1'b1; // sticky until reset

			if (diskreset)
				disk_pos <= '0;
			else if (rd_open && !disk_end)
				disk_pos <= disk_pos + 16'd1; // one byte per read sequence
		end
	end

	assign disk_end  = (disk_pos == fds_pkg::DISK_POS_LAST);
	assign side_base = {{(fds_pkg::DISK_OFS_W-2){1'b0}}, side} * fds_pkg::DISK_SIDE_BYTES;
	assign disk_ofs  = {2'b00, disk_pos} + fds_pkg::DISK_HEADER_BYTES + side_base;

	assign ctrl.vertical = vertical;
	assign ctrl.io_en    = io_en;
	assign ctrl.rd_open  = rd_open;
	assign ctrl.wr_open  = wr_open;

endmodule

// File: src/fds_mapper.sv
// FDS mapper top: timer, disk sequencer, address map and readback mux on one cpu bus
`timescale 1ns/10ps

module fds_mapper (
	input  logic                            clk20,
	input  logic                            reset,
	input  logic                            cpu_ce,
	input  fds_pkg::cpu_bus_t               bus,
	input  logic [7:0]                      ram_rdata,
	input  logic                            disk_swap,
	output logic [7:0]                      rdata,
	output logic [fds_pkg::PRG_AOUT_W-1:0]  prg_aout,
	output logic                            prg_allow,
	output fds_pkg::chr_map_t               chr,
	output logic                            irq
);

	fds_pkg::disk_ctrl_t            ctrl;
	logic [fds_pkg::DISK_OFS_W-1:0] disk_ofs;
	logic                           io_en;
	logic                           disk_end;
	logic                           saved;

	fds_timer_irq timer_irq_inst (
		.clk20  (clk20),
		.reset  (reset),
		.cpu_ce (cpu_ce),
		.bus    (bus),
		.irq    (irq),
		.io_en  (io_en)
	);

	fds_disk_seq disk_seq_inst (
		.clk20    (clk20),
		.reset    (reset),
		.cpu_ce   (cpu_ce),
		.bus      (bus),
		.io_en    (io_en),
		.ctrl     (ctrl),
		.disk_ofs (disk_ofs),
		.disk_end (disk_end),
		.saved    (saved)
	);

	fds_addr_map addr_map_inst (
		.bus       (bus),
		.ctrl      (ctrl),
		.disk_ofs  (disk_ofs),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr       (chr)
	);

	fds_read_mux read_mux_inst (
		.bus       (bus),
		.ram_rdata (ram_rdata),
		.irq       (irq),
		.disk_swap (disk_swap),
		.disk_end  (disk_end),
		.saved     (saved),
		.ctrl      (ctrl),
		.disk_ofs  (disk_ofs),
		.rdata     (rdata)
	);

endmodule

// File: src/fds_pkg.sv
// shared addresses, disk geometry, bus and map types for the FDS mapper; referenced by scoped names
package fds_pkg;

	// widths
	localparam int DISK_POS_W = 16;
	localparam int DISK_OFS_W = 18;
	localparam int PRG_AOUT_W = 19;
	localparam int CHR_BANK_W = 9;

	// timer and io registers
	localparam logic [15:0] REG_TIMER_LO     = 16'h4020;
	localparam logic [15:0] REG_TIMER_HI     = 16'h4021;
	localparam logic [15:0] REG_TIMER_CTRL   = 16'h4022;
	localparam logic [15:0] REG_IO_EN        = 16'h4023;

	// disk control and status
	localparam logic [15:0] REG_DISK_CTRL    = 16'h4025;
	localparam logic [15:0] REG_DISK_SIDE    = 16'h4027; // side select, not a real FDS register
	localparam logic [15:0] REG_IRQ_STATUS   = 16'h4030;
	localparam logic [15:0] REG_DRIVE_STATUS = 16'h4032;
	localparam logic [15:0] REG_EXT_STATUS   = 16'h4033;
	localparam logic [15:0] REG_SAVE_FLAG    = 16'h4208;

	// bios handshake addresses, lo then hi
	localparam logic [15:0] DISK_WRITE_LO    = 16'hF4CD;
	localparam logic [15:0] DISK_WRITE_HI    = 16'hF4CE;
	localparam logic [15:0] DISK_READ_LO     = 16'hF4D0;
	localparam logic [15:0] DISK_READ_HI     = 16'hF4D1;

	// disk image geometry
	localparam logic [DISK_OFS_W-1:0] DISK_SIDE_BYTES   = 18'd65500;
	localparam logic [DISK_OFS_W-1:0] DISK_HEADER_BYTES = 18'd16; // image header before side 0
	localparam logic [DISK_POS_W-1:0] DISK_POS_LAST     = 16'd65499;

	localparam logic [7:0] EXT_STATUS_VALUE = 8'h80; // battery good

	// one cpu cycle, valid while cpu_ce is high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        write;
	} cpu_bus_t;

	// chr side mapping
	typedef struct packed {
		logic [CHR_BANK_W-1:0] chr_bank; // address bits 18..10
		logic                  ciram_ce;
	} chr_map_t;

	// lo/hi handshake state, shared by read and write sequencers
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ARMED,
		SEQ_OPEN
	} seq_state_t;

	// disk control bits handed to the map and readback blocks
	typedef struct packed {
		logic vertical;
		logic io_en;
		logic rd_open;  // read window open this cycle
		logic wr_open;  // write window open this cycle
	} disk_ctrl_t;

endpackage

// File: src/fds_read_mux.sv
// combinational cpu readback over status registers, disk offset ports and external ram data
`timescale 1ns/10ps

module fds_read_mux (
	input  fds_pkg::cpu_bus_t               bus,
	input  logic [7:0]                      ram_rdata,
	input  logic                            irq,
	input  logic                            disk_swap,
	input  logic                            disk_end,
	input  logic                            saved,
	input  fds_pkg::disk_ctrl_t             ctrl,
	input  logic [fds_pkg::DISK_OFS_W-1:0]  disk_ofs,
	output logic [7:0]                      rdata
);

	logic window_open;
	logic hit_lo;
	logic hit_hi;

	assign window_open = ctrl.rd_open | ctrl.wr_open;

	// offset ports only answer while no window is open
	assign hit_lo = ((bus.addr == fds_pkg::DISK_READ_LO) |
	                 (bus.addr == fds_pkg::DISK_WRITE_LO)) & ~window_open;
	assign hit_hi = ((bus.addr == fds_pkg::DISK_READ_HI) |
	                 (bus.addr == fds_pkg::DISK_WRITE_HI)) & ~window_open;

	always_comb begin
		if (bus.addr == fds_pkg::REG_IRQ_STATUS)
			rdata = {7'd0, irq};
		else if (bus.addr == fds_pkg::REG_DRIVE_STATUS)
			rdata = {5'd0, disk_swap, disk_end, disk_swap}; // eject shows in bits 0 and 2
		else if (bus.addr == fds_pkg::REG_EXT_STATUS)
			rdata = fds_pkg::EXT_STATUS_VALUE;
		else if (hit_lo)
			rdata = disk_ofs[7:0];
		else if (hit_hi)
			rdata = {3'b111, disk_ofs[12:8]};
		else if (bus.addr == fds_pkg::REG_SAVE_FLAG)
			rdata = {7'd0, saved};
		else
			rdata = ram_rdata; // everything else from memory
	end

endmodule

// File: src/fds_timer_irq.sv
// FDS timer IRQ: reload latch, countdown, enable/repeat and $4030 acknowledge, stepped by cpu_ce
`timescale 1ns/10ps

module fds_timer_irq (
	input  logic              clk20,
	input  logic              reset,
	input  logic              cpu_ce,
	input  fds_pkg::cpu_bus_t bus,
	output logic              irq,
	output logic              io_en
);

	logic [15:0] timer_latch;
	logic [15:0] timer;
	logic        timer_en;
	logic        timer_repeat;
	logic        wr_cyc;
	logic        ack;

	assign wr_cyc = cpu_ce & bus.write;
	assign ack    = cpu_ce & ~bus.write & (bus.addr == fds_pkg::REG_IRQ_STATUS);

	always_ff @(posedge clk20) begin
		if (reset) begin
			irq          <= 1'b0;
			io_en        <= 1'b0;
			timer_en     <= 1'b0;
			timer_repeat <= 1'b0;
		end else begin
			if (cpu_ce && timer_en) begin
				if (timer == 16'd0) begin
					irq   <= 1'b1;
					timer <= timer_latch; // reload on expiry
					if (!timer_repeat)
						timer_en <= 1'b0; // one-shot
				end else begin
					timer <= timer - 16'd1;
				end
			end

			// register writes override the countdown
			if (wr_cyc) begin
				case (bus.addr)
					fds_pkg::REG_TIMER_LO: timer_latch[7:0]  <= bus.wdata;
					fds_pkg::REG_TIMER_HI: timer_latch[15:8] <= bus.wdata;
					fds_pkg::REG_TIMER_CTRL: begin
						timer_repeat <= bus.wdata[0];
						timer_en     <= bus.wdata[1] & io_en;
						if (bus.wdata[1] && io_en)
							timer <= timer_latch;
						else
							irq <= 1'b0;
					end
					fds_pkg::REG_IO_EN: begin
						io_en <= bus.wdata[0];
						if (!bus.wdata[0]) begin
							timer_en <= 1'b0; // disk registers off stops the timer
							irq      <= 1'b0;
						end
					end
					default: ;
				endcase
			end

			// status read acknowledges, wins over a set on the same edge
			if (ack)
				irq <= 1'b0;
		end
	end

endmodule

// File: verification/fds_model.svh
// reference model of the FDS mapper state and outputs; included inside the testbench module
`ifndef FDS_MODEL_SVH
`define FDS_MODEL_SVH

logic [15:0] m_latch;
logic [15:0] m_timer;
logic        m_en;
logic        m_rep;
logic        m_irq;
logic        m_io_en;
int          m_rd_state;   // 0 idle, 1 armed, 2 open
int          m_wr_state;
logic [15:0] m_pos;
logic [1:0]  m_side;
logic        m_diskreset;
logic        m_write_en;
logic        m_vertical;
logic        m_saved;

task automatic model_reset();
	m_latch = '0;
	m_timer = '0;
	{m_en, m_rep, m_irq, m_io_en} = 4'b0000;
	m_rd_state = 0;
	m_wr_state = 0;
	m_pos = '0;
	m_side = 2'd0;
	{m_diskreset, m_write_en, m_vertical, m_saved} = 4'b0000;
endtask

function automatic logic win();
	return (m_rd_state == 2) || (m_wr_state == 2);
endfunction

function automatic logic [17:0] pred_ofs();
	logic [31:0] t;
	t = 32'd16 + 32'd65500 * {30'd0, m_side} + {16'd0, m_pos};
	return t[17:0];
endfunction

// state after the clock edge that takes this cycle
task automatic model_step(input logic [15:0] a, input logic [7:0] d, input logic w,
	input logic ce);
	logic [15:0] latch_n;
	logic [15:0] timer_n;
	logic        en_n;
	logic        rep_n;
	logic        irq_n;
	logic        io_n;
	if (!ce)
		return;
	{latch_n, timer_n, en_n, rep_n, irq_n, io_n} = {m_latch, m_timer, m_en, m_rep, m_irq, m_io_en};
	if (m_en) begin
		if (m_timer == 16'd0) begin
			irq_n = 1'b1;
			timer_n = m_latch;
			if (!m_rep)
				en_n = 1'b0;
		end else
			timer_n = m_timer - 16'd1;
	end
	if (w && a == 16'h4020) latch_n[7:0] = d;
	if (w && a == 16'h4021) latch_n[15:8] = d;
	if (w && a == 16'h4022) begin
		rep_n = d[0];
		en_n = d[1] & m_io_en;
		if (d[1] && m_io_en)
			timer_n = m_latch;
		else
			irq_n = 1'b0;
	end
	if (w && a == 16'h4023) begin
		io_n = d[0];
		if (!d[0])
			{en_n, irq_n} = 2'b00;
	end
	if (!w && a == 16'h4030)
		irq_n = 1'b0; // ack beats a set
	{m_latch, m_timer, m_en, m_rep, m_irq, m_io_en} = {latch_n, timer_n, en_n, rep_n, irq_n, io_n};

	// disk side, old state first
	if (m_wr_state == 2)
		m_saved = 1'b1;
	if (m_diskreset)
		m_pos = '0;
	else if (m_rd_state == 2 && m_pos != 16'd65499)
		m_pos = m_pos + 16'd1;
	if (!w && a == 16'hF4CD && m_write_en) m_wr_state = 1;
	else if (!w && a == 16'hF4CE && m_wr_state == 1) m_wr_state = 2;
	else m_wr_state = 0;
	if (!w && a == 16'hF4D0) m_rd_state = 1;
	else if (!w && a == 16'hF4D1 && m_rd_state == 1) m_rd_state = 2;
	else m_rd_state = 0;
	if (w && a == 16'h4025)
		{m_vertical, m_write_en, m_diskreset} = {~d[3], ~d[2], d[1]};
	if (w && a == 16'h4027)
		m_side = d[1:0];
endtask

`endif

// File: verification/fds_tb.sv
// simulation top that drives fds_mapper with directed and random cpu cycles against the included model
`timescale 1ns/10ps

module fds_tb;

	logic                           clk20;
	logic                           reset;
	logic                           cpu_ce;
	logic                           disk_swap;
	logic [7:0]                     ram_rdata;
	logic [7:0]                     rdata;
	fds_pkg::cpu_bus_t              bus;
	logic [fds_pkg::PRG_AOUT_W-1:0] prg_aout;
	logic                           prg_allow;
	fds_pkg::chr_map_t              chr;
	logic                           irq;
	int                             errors;
	int                             checks;
	int                             tests;
	logic [15:0]       reg_list [16] = '{16'h4020, 16'h4021, 16'h4022, 16'h4023, 16'h4024,
		16'h4025, 16'h4027, 16'h4030, 16'h4031, 16'h4032, 16'h4033, 16'h4208,
		16'hF4CD, 16'hF4CE, 16'hF4D0, 16'hF4D1};

	`include "fds_model.svh"

	fds_mapper fds_mapper_inst (
		.clk20(clk20), .reset(reset), .cpu_ce(cpu_ce), .bus(bus), .ram_rdata(ram_rdata),
		.disk_swap(disk_swap), .rdata(rdata), .prg_aout(prg_aout), .prg_allow(prg_allow),
		.chr(chr), .irq(irq)
	);

	initial begin
		clk20 = 1'b0;
		forever #20 clk20 = ~clk20;
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h (addr %h)", name, got, exp, bus.addr);
			errors++;
		end
	endtask

	task automatic check_prg(input logic [fds_pkg::PRG_AOUT_W-1:0] got_a, input logic got_ok,
		input logic [fds_pkg::PRG_AOUT_W-1:0] exp_a, input logic exp_ok);
		checks++;
		if (got_a !== exp_a || got_ok !== exp_ok) begin
			$display("Mismatch prg_aout/prg_allow: got %h/%h expected %h/%h (addr %h)",
				got_a, got_ok, exp_a, exp_ok, bus.addr);
			errors++;
		end
	endtask

	task automatic check_chr(input fds_pkg::chr_map_t got, input fds_pkg::chr_map_t exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch chr: got %h expected %h (addr %h)", got, exp, bus.addr);
			errors++;
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch irq: got %h expected %h", got, exp);
			errors++;
		end
	endtask

	function automatic logic [7:0] pred_rdata(input logic [15:0] a, input logic [7:0] ram,
		input logic swap);
		logic [17:0] ofs;
		ofs = pred_ofs();
		if (a == 16'h4030) return {7'd0, m_irq};
		if (a == 16'h4032) return {5'd0, swap, m_pos == 16'd65499, swap};
		if (a == 16'h4033) return 8'h80;
		if ((a == 16'hF4D0 || a == 16'hF4CD) && !win()) return ofs[7:0];
		if ((a == 16'hF4D1 || a == 16'hF4CE) && !win()) return {3'b111, ofs[12:8]};
		if (a == 16'h4208) return {7'd0, m_saved};
		return ram;
	endfunction

	// allow bit on top of the bank address
	function automatic logic [19:0] pred_prg(input logic [15:0] a, input logic w);
		logic [17:0] ofs;
		logic [5:0]  bank;
		logic        ok;
		logic        port;
		ofs = pred_ofs();
		port = (a == 16'hF4CD || a == 16'hF4CE || a == 16'hF4D0 || a == 16'hF4D1) && !win();
		if (a >= 16'hE000)
			bank = win() ? {1'b1, ofs[17:13]} : 6'd0;
		else
			bank = {4'b0001, a[14:13]};
		if (w)
			ok = (m_wr_state == 2) || (a >= 16'h6000 && a <= 16'hDFFF);
		else
			ok = (a >= 16'h6000 && a <= 16'h7FFF) || (a >= 16'h8000 && !port);
		return {ok, bank, a[12:0]};
	endfunction

	function automatic fds_pkg::chr_map_t pred_chr(input logic [15:0] a);
		fds_pkg::chr_map_t c;
		c.chr_bank = {6'd0, a[12:11], (a[13] && !m_vertical) ? a[11] : a[10]};
		c.ciram_ce = a[13];
		return c;
	endfunction

	// drive on the rising edge and check mid cycle before the model advances
	task automatic drive(input logic [15:0] a, input logic [7:0] d, input logic w, input logic ce);
		logic [31:0] r;
		logic [19:0] p;
		r = $urandom;
		@(posedge clk20);
		bus.addr <= a;
		bus.wdata <= d;
		bus.write <= w;
		cpu_ce <= ce;
		ram_rdata <= r[7:0];
		disk_swap <= r[8];
		@(negedge clk20);
		p = pred_prg(a, w);
		check_byte("rdata", rdata, pred_rdata(a, r[7:0], r[8]));
		check_prg(prg_aout, prg_allow, p[18:0], p[19]);
		check_chr(chr, pred_chr(a));
		check_irq(irq, m_irq);
		model_step(a, d, w, ce);
	endtask

	task automatic rd(input logic [15:0] a);
		logic [31:0] r;
		r = $urandom;
		drive(a, r[7:0], 1'b0, 1'b1);
	endtask

	task automatic wr(input logic [15:0] a, input logic [7:0] d);
		drive(a, d, 1'b1, 1'b1);
	endtask

	task automatic wait_irq(input int limit, output int n);
		n = 0;
		do begin
			rd(16'h0000);
			n++;
		end while (!irq && n < limit);
		if (!irq) begin
			$display("timeout: irq never rose within %0d cycles", limit);
			errors++;
		end
	endtask

	function automatic logic [15:0] rand_addr();
		logic [31:0] r;
		r = $urandom;
		case (r[2:0])
			3'd0, 3'd1, 3'd2: return reg_list[r[6:3]];
			3'd3, 3'd4, 3'd5: return 16'h6000 + (r[31:16] % 16'hA000);
			default: return {2'b00, r[29:16]};
		endcase
	endfunction

	task automatic end_test(input string name, input int e0);
		tests++;
		$display("test %s: %s", name, (errors == e0) ? "ok" : "errors");
	endtask

	initial begin
		int          e0;
		int          n;
		int          lat;
		logic [31:0] r;
		void'($urandom(32'hb08ccc28));
		{errors, checks, tests} = {32'd0, 32'd0, 32'd0};
		reset = 1'b1;
		cpu_ce = 1'b0;
		bus = '0;
		ram_rdata = 8'h00;
		disk_swap = 1'b0;
		model_reset();
		repeat (4) @(posedge clk20);
		reset <= 1'b0;

		e0 = errors; // timer irq, repeat, ack, disable
		r = $urandom;
		lat = int'(r[3:0]) + 2;
		wr(16'h4023, 8'h01);
		wr(16'h4020, lat[7:0]);
		wr(16'h4021, 8'h00);
		wr(16'h4022, 8'h03);
		wait_irq(100, n);
		if (irq && n != lat + 2) begin
			$display("irq rose after %0d cycles instead of %0d", n, lat + 2);
			errors++;
		end
		rd(16'h4030);
		wait_irq(100, n); // repeat reload
		wr(16'h4023, 8'h00);
		repeat (40) rd(16'h0000);
		if (irq) begin
			$display("irq still raised after the disk io was disabled");
			errors++;
		end
		end_test("timer_irq", e0);

		e0 = errors; // read window on the bios bank
		wr(16'h4025, 8'h02);
		wr(16'h4025, 8'h00);
		repeat (20) begin
			r = $urandom;
			rd(16'hF4D0);
			rd(16'hF4D1);
			rd({3'b111, r[12:0]});
			rd({3'b111, r[28:16]});
		end
		wr(16'h4025, 8'h02); // pointer back to the start of the side
		wr(16'h4025, 8'h00);
		rd(16'hF4D0);
		end_test("read_window", e0);

		e0 = errors; // side, offset readback, end of side
		r = $urandom;
		wr(16'h4027, {6'd0, r[1:0]});
		rd(16'hF4D0);
		rd(16'hF4D1);
		n = 0;
		do begin
			rd(16'hF4D0);
			rd(16'hF4D1);
			rd(16'h4032);
			n++;
		end while (!rdata[1] && n < 70000);
		if (!rdata[1]) begin
			$display("timeout: disk_end never reported at $4032");
			errors++;
		end
		rd(16'hF4D0);
		rd(16'hF4D1);
		end_test("side_offset", e0);

		e0 = errors; // write window and save flag
		r = $urandom;
		wr(16'h4025, 8'h00);
		rd(16'hF4CD);
		rd(16'hF4CE);
		wr({2'b00, r[13:0]}, r[23:16]);
		if (!prg_allow) begin
			$display("write window did not grant the write");
			errors++;
		end
		rd(16'h4208);
		if (!rdata[0]) begin
			$display("save flag not set after a write window");
			errors++;
		end
		wr(16'h4025, 8'h04);
		rd(16'hF4CD);
		rd(16'hF4CE);
		wr({2'b00, r[13:0]}, r[23:16]);
		if (prg_allow) begin
			$display("write window opened with write disabled");
			errors++;
		end
		end_test("write_window", e0);

		e0 = errors; // random mix over map, mirroring and readback
		for (int i = 0; i < 4000; i++) begin
			r = $urandom;
			if (i % 500 == 0)
				wr(16'h4025, {4'd0, r[20], 3'b000});
			else if (r[2:0] == 3'd0)
				drive(bus.addr, bus.wdata, bus.write, 1'b0);
			else
				drive(rand_addr(), r[15:8], r[5:4] == 2'b00, 1'b1);
		end
		end_test("random_mix", e0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
